// ==== rtl/dc_params.svh ====
`ifndef DC_PARAMS_SVH
`define DC_PARAMS_SVH

// --------------------------------------------------
// core side field widths
// --------------------------------------------------
// pc signature carried with each core op
`define DC_PCSIGN_W   13
// offset inside a 4KB page
`define DC_POFFSET_W  12
// load data line returned to the core
`define DC_LINE_W     64

// --------------------------------------------------
// l2 side field widths
// --------------------------------------------------
`define DC_PPADDR_W   27
// hashed page, used for the l2 tlb lookup
`define DC_HPADDR_W   11
`define DC_L2ID_W     6

// entries per fluid flop, dc_fflop is written for two
`define DC_FF_DEPTH   2

`endif

// ==== rtl/dc_core_pkg.sv ====
`include "dc_params.svh"

package dc_core_pkg;

  // --------------------------------------------------
  // core facing fields
  // --------------------------------------------------

  // pc signature of the load or store, passed to l2 untouched
  typedef logic [`DC_PCSIGN_W-1:0] pcsign_t;

  // page offset from the core op
  // the page number comes from the tlb forward instead
  typedef logic [`DC_POFFSET_W-1:0] poffset_t;

  // data line handed back to the core on a load
  typedef logic [`DC_LINE_W-1:0] line_t;

endpackage

// ==== rtl/dc_l2_pkg.sv ====
`include "dc_params.svh"

package dc_l2_pkg;

  // --------------------------------------------------
  // l2 facing fields
  // --------------------------------------------------
  typedef logic [`DC_PPADDR_W-1:0] ppaddr_t;
  typedef logic [`DC_HPADDR_W-1:0] hpaddr_t;
  // tag that pairs a snack with its snoop ack
  typedef logic [`DC_L2ID_W-1:0] l2id_t;

  // request command, loads ask for shared and stores for exclusive
  typedef enum logic [1:0] {
    cmd_req_s = 2'b00,
    cmd_req_m = 2'b01
  } l2_cmd_e;

  // occupancy of a fluid flop
  typedef enum logic [1:0] {
    ff_empty = 2'd0,
    ff_one   = 2'd1,
    ff_two   = 2'd2
  } ff_state_e;

endpackage

// ==== rtl/dc_fflop.sv ====
`timescale 1ns/1ps
`include "dc_params.svh"

module dc_fflop
  import dc_l2_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_retry,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_retry,
  output logic [WIDTH-1:0] out_data
);

  ff_state_e state_q;
  ff_state_e state_d;
  // entry 0 is the head shown on the output, entry 1 the spill slot
  logic [WIDTH-1:0] entry_q [`DC_FF_DEPTH];
  logic push;
  logic pop;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  assign push = in_valid && !in_retry;
  assign pop  = out_valid && !out_retry;

  // retry decodes only the state flop, so the upstream never sees
  // a path from out_retry to in_retry
  assign in_retry  = (state_q == ff_two);
  assign out_valid = (state_q != ff_empty);
  assign out_data  = entry_q[0];

  // --------------------------------------------------
  // occupancy
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ff_empty: begin
        if (push) begin
          state_d = ff_one;
        end
      end
      ff_one: begin
        if (push && !pop) begin
          state_d = ff_two;
        end else if (pop && !push) begin
          state_d = ff_empty;
        end
      end
      ff_two: begin
        // full, no push possible this cycle
        if (pop) begin
          state_d = ff_one;
        end
      end
      default: begin
        state_d = ff_empty;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ff_empty;
    end else begin
      state_q <= state_d;
    end
  end

  // payload, head is refilled from input or from the spill slot
  always_ff @(posedge clk) begin
    if ((state_q == ff_empty && push) || (state_q == ff_one && push && pop)) begin
      entry_q[0] <= in_data;
    end else if (state_q == ff_two && pop) begin
      entry_q[0] <= entry_q[1];
    end
    if (state_q == ff_one && push && !pop) begin
      entry_q[1] <= in_data;
    end
  end

endmodule

// ==== rtl/dc_miss_arb.sv ====
`timescale 1ns/1ps

module dc_miss_arb
  import dc_core_pkg::*, dc_l2_pkg::*;
(
  // load pair
  input  logic     ld_valid,
  output logic     ld_retry,
  input  pcsign_t  ld_pcsign,
  input  poffset_t ld_poffset,
  input  logic     fwd0_valid,
  output logic     fwd0_retry,
  input  ppaddr_t  fwd0_ppaddr,
  input  hpaddr_t  fwd0_hpaddr,
  // store pair
  input  logic     std_valid,
  output logic     std_retry,
  input  pcsign_t  std_pcsign,
  input  poffset_t std_poffset,
  input  logic     fwd1_valid,
  output logic     fwd1_retry,
  input  ppaddr_t  fwd1_ppaddr,
  input  hpaddr_t  fwd1_hpaddr,
  // l2 request
  output logic     req_valid,
  input  logic     req_retry,
  output l2_cmd_e  req_cmd,
  output pcsign_t  req_pcsign,
  output poffset_t req_poffset,
  output ppaddr_t  req_ppaddr,
  // l2 tlb request
  output logic     tlb_valid,
  input  logic     tlb_retry,
  output hpaddr_t  tlb_hpaddr,
  // store ack to core
  output logic     ack_valid,
  input  logic     ack_retry
);

  logic ld_rdy;
  logic st_rdy;
  logic req_free;
  logic ld_fire;
  logic st_fire;

  // --------------------------------------------------
  // join and priority
  // --------------------------------------------------
  // a pair is ready once the core op and its tlb forward are both there
  assign ld_rdy = ld_valid && fwd0_valid;
  assign st_rdy = std_valid && fwd1_valid;

  // l2 request and tlb request always leave together
  assign req_free = !req_retry && !tlb_retry;

  // fixed priority, a ready load blocks the store even when
  // the load itself is held by retry
  assign ld_fire = ld_rdy && req_free;
  assign st_fire = !ld_rdy && st_rdy && req_free && !ack_retry;

  // pop both halves of a pair in the firing cycle only
  assign ld_retry   = !ld_fire;
  assign fwd0_retry = !ld_fire;
  assign std_retry  = !st_fire;
  assign fwd1_retry = !st_fire;

  // --------------------------------------------------
  // fork to the output buffers
  // --------------------------------------------------
  // valids are qualified by fire, otherwise one buffer could take
  // a word that another buffer refused
  assign req_valid = ld_fire || st_fire;
  assign tlb_valid = ld_fire || st_fire;
  // ack only travels with a store request
  assign ack_valid = st_fire;

  // payload mux follows the same priority as the fire logic
  always_comb begin
    if (ld_rdy) begin
      req_cmd     = cmd_req_s;
      req_pcsign  = ld_pcsign;
      req_poffset = ld_poffset;
      req_ppaddr  = fwd0_ppaddr;
      tlb_hpaddr  = fwd0_hpaddr;
    end else begin
      // stores need the line exclusive
      req_cmd     = cmd_req_m;
      req_pcsign  = std_pcsign;
      req_poffset = std_poffset;
      req_ppaddr  = fwd1_ppaddr;
      tlb_hpaddr  = fwd1_hpaddr;
    end
  end

endmodule

// ==== rtl/dc_snack_fork.sv ====
`timescale 1ns/1ps

module dc_snack_fork
  import dc_core_pkg::*, dc_l2_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  snack_valid,
  output logic  snack_retry,
  input  l2id_t snack_l2id,
  input  line_t snack_line,
  output logic  ld_valid,
  input  logic  ld_retry,
  output line_t ld_data,
  output logic  sack_valid,
  input  logic  sack_retry,
  output l2id_t sack_l2id
);

  // set once a branch has taken the current snack
  logic ld_done_q;
  logic sack_done_q;
  logic ld_take;
  logic sack_take;
  logic ld_fin;
  logic sack_fin;
  logic pop;

  // offer each branch only what it has not taken yet
  assign ld_valid   = snack_valid && !ld_done_q;
  assign sack_valid = snack_valid && !sack_done_q;
  assign ld_data    = snack_line;
  assign sack_l2id  = snack_l2id;

  assign ld_take   = ld_valid && !ld_retry;
  assign sack_take = sack_valid && !sack_retry;

  // branch finished earlier or finishing now
  assign ld_fin   = ld_done_q || ld_take;
  assign sack_fin = sack_done_q || sack_take;

  // release the snack when the last branch takes it
  assign pop         = snack_valid && ld_fin && sack_fin;
  assign snack_retry = !pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_done_q   <= 1'b0;
      sack_done_q <= 1'b0;
    end else if (pop) begin
      ld_done_q   <= 1'b0;
      sack_done_q <= 1'b0;
    end else begin
      ld_done_q   <= ld_fin;
      sack_done_q <= sack_fin;
    end
  end

endmodule

// ==== rtl/dcache_pipe.sv ====
`timescale 1ns/1ps

module dcache_pipe
  import dc_core_pkg::*, dc_l2_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // core load in
  input  logic     coretodc_ld_valid,
  output logic     coretodc_ld_retry,
  input  pcsign_t  ld_pcsign,
  input  poffset_t ld_poffset,
  // core store in
  input  logic     coretodc_std_valid,
  output logic     coretodc_std_retry,
  input  pcsign_t  std_pcsign,
  input  poffset_t std_poffset,
  // tlb forwards, fwd0 pairs with loads and fwd1 with stores
  input  logic     l1tlbtol1_fwd0_valid,
  output logic     l1tlbtol1_fwd0_retry,
  input  ppaddr_t  fwd0_ppaddr,
  input  hpaddr_t  fwd0_hpaddr,
  input  logic     l1tlbtol1_fwd1_valid,
  output logic     l1tlbtol1_fwd1_retry,
  input  ppaddr_t  fwd1_ppaddr,
  input  hpaddr_t  fwd1_hpaddr,
  // snoop or ack from l2
  input  logic     l2tol1_snack_valid,
  output logic     l2tol1_snack_retry,
  input  l2id_t    snack_l2id,
  input  line_t    snack_line,
  // l2 request out
  output logic     l1tol2_req_valid,
  input  logic     l1tol2_req_retry,
  output l2_cmd_e  req_cmd,
  output pcsign_t  req_pcsign,
  output poffset_t req_poffset,
  output ppaddr_t  req_ppaddr,
  // l2 tlb request out
  output logic     l1tol2tlb_req_valid,
  input  logic     l1tol2tlb_req_retry,
  output hpaddr_t  tlb_hpaddr,
  // store ack, valid only
  output logic     dctocore_std_ack_valid,
  input  logic     dctocore_std_ack_retry,
  // load data to core
  output logic     dctocore_ld_valid,
  input  logic     dctocore_ld_retry,
  output line_t    ld_data,
  // snoop ack to l2
  output logic     l1tol2_snoop_ack_valid,
  input  logic     l1tol2_snoop_ack_retry,
  output l2id_t    ack_l2id
);

  localparam int OP_W    = $bits(pcsign_t) + $bits(poffset_t);
  localparam int FWD_W   = $bits(ppaddr_t) + $bits(hpaddr_t);
  localparam int SNACK_W = $bits(l2id_t) + $bits(line_t);
  localparam int REQ_W   = $bits(l2_cmd_e) + OP_W + $bits(ppaddr_t);

  // ib_ is the output side of an input buffer
  logic     ib_ld_valid;
  logic     ib_ld_retry;
  pcsign_t  ib_ld_pcsign;
  poffset_t ib_ld_poffset;
  logic     ib_std_valid;
  logic     ib_std_retry;
  pcsign_t  ib_std_pcsign;
  poffset_t ib_std_poffset;
  logic     ib_fwd0_valid;
  logic     ib_fwd0_retry;
  ppaddr_t  ib_fwd0_ppaddr;
  hpaddr_t  ib_fwd0_hpaddr;
  logic     ib_fwd1_valid;
  logic     ib_fwd1_retry;
  ppaddr_t  ib_fwd1_ppaddr;
  hpaddr_t  ib_fwd1_hpaddr;
  logic     ib_snack_valid;
  logic     ib_snack_retry;
  l2id_t    ib_snack_l2id;
  line_t    ib_snack_line;
  // ob_ is the input side of an output buffer
  logic     ob_req_valid;
  logic     ob_req_retry;
  l2_cmd_e  ob_req_cmd;
  pcsign_t  ob_req_pcsign;
  poffset_t ob_req_poffset;
  ppaddr_t  ob_req_ppaddr;
  logic     ob_tlb_valid;
  logic     ob_tlb_retry;
  hpaddr_t  ob_tlb_hpaddr;
  logic     ob_ack_valid;
  logic     ob_ack_retry;
  logic     ob_ld_valid;
  logic     ob_ld_retry;
  line_t    ob_ld_data;
  logic     ob_sack_valid;
  logic     ob_sack_retry;
  l2id_t    ob_sack_l2id;
  // command leaves its buffer as raw bits
  logic [$bits(l2_cmd_e)-1:0] req_cmd_bits;

  assign req_cmd = l2_cmd_e'(req_cmd_bits);

  // --------------------------------------------------
  // input buffers
  // --------------------------------------------------
  dc_fflop #(.WIDTH(OP_W)) u_ff_ld (
    .clk(clk), .rst_n(rst_n),
    .in_valid(coretodc_ld_valid), .in_retry(coretodc_ld_retry),
    .in_data({ld_pcsign, ld_poffset}),
    .out_valid(ib_ld_valid), .out_retry(ib_ld_retry),
    .out_data({ib_ld_pcsign, ib_ld_poffset})
  );

  dc_fflop #(.WIDTH(OP_W)) u_ff_std (
    .clk(clk), .rst_n(rst_n),
    .in_valid(coretodc_std_valid), .in_retry(coretodc_std_retry),
    .in_data({std_pcsign, std_poffset}),
    .out_valid(ib_std_valid), .out_retry(ib_std_retry),
    .out_data({ib_std_pcsign, ib_std_poffset})
  );

  dc_fflop #(.WIDTH(FWD_W)) u_ff_fwd0 (
    .clk(clk), .rst_n(rst_n),
    .in_valid(l1tlbtol1_fwd0_valid), .in_retry(l1tlbtol1_fwd0_retry),
    .in_data({fwd0_ppaddr, fwd0_hpaddr}),
    .out_valid(ib_fwd0_valid), .out_retry(ib_fwd0_retry),
    .out_data({ib_fwd0_ppaddr, ib_fwd0_hpaddr})
  );

  dc_fflop #(.WIDTH(FWD_W)) u_ff_fwd1 (
    .clk(clk), .rst_n(rst_n),
    .in_valid(l1tlbtol1_fwd1_valid), .in_retry(l1tlbtol1_fwd1_retry),
    .in_data({fwd1_ppaddr, fwd1_hpaddr}),
    .out_valid(ib_fwd1_valid), .out_retry(ib_fwd1_retry),
    .out_data({ib_fwd1_ppaddr, ib_fwd1_hpaddr})
  );

  dc_fflop #(.WIDTH(SNACK_W)) u_ff_snack (
    .clk(clk), .rst_n(rst_n),
    .in_valid(l2tol1_snack_valid), .in_retry(l2tol1_snack_retry),
    .in_data({snack_l2id, snack_line}),
    .out_valid(ib_snack_valid), .out_retry(ib_snack_retry),
    .out_data({ib_snack_l2id, ib_snack_line})
  );

  // --------------------------------------------------
  // steering
  // --------------------------------------------------
  dc_miss_arb u_miss_arb (
    .ld_valid(ib_ld_valid), .ld_retry(ib_ld_retry),
    .ld_pcsign(ib_ld_pcsign), .ld_poffset(ib_ld_poffset),
    .fwd0_valid(ib_fwd0_valid), .fwd0_retry(ib_fwd0_retry),
    .fwd0_ppaddr(ib_fwd0_ppaddr), .fwd0_hpaddr(ib_fwd0_hpaddr),
    .std_valid(ib_std_valid), .std_retry(ib_std_retry),
    .std_pcsign(ib_std_pcsign), .std_poffset(ib_std_poffset),
    .fwd1_valid(ib_fwd1_valid), .fwd1_retry(ib_fwd1_retry),
    .fwd1_ppaddr(ib_fwd1_ppaddr), .fwd1_hpaddr(ib_fwd1_hpaddr),
    .req_valid(ob_req_valid), .req_retry(ob_req_retry), .req_cmd(ob_req_cmd),
    .req_pcsign(ob_req_pcsign), .req_poffset(ob_req_poffset),
    .req_ppaddr(ob_req_ppaddr),
    .tlb_valid(ob_tlb_valid), .tlb_retry(ob_tlb_retry), .tlb_hpaddr(ob_tlb_hpaddr),
    .ack_valid(ob_ack_valid), .ack_retry(ob_ack_retry)
  );

  dc_snack_fork u_snack_fork (
    .clk(clk), .rst_n(rst_n),
    .snack_valid(ib_snack_valid), .snack_retry(ib_snack_retry),
    .snack_l2id(ib_snack_l2id), .snack_line(ib_snack_line),
    .ld_valid(ob_ld_valid), .ld_retry(ob_ld_retry), .ld_data(ob_ld_data),
    .sack_valid(ob_sack_valid), .sack_retry(ob_sack_retry), .sack_l2id(ob_sack_l2id)
  );

  // --------------------------------------------------
  // output buffers
  // --------------------------------------------------
  dc_fflop #(.WIDTH(REQ_W)) u_ff_req (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ob_req_valid), .in_retry(ob_req_retry),
    .in_data({ob_req_cmd, ob_req_pcsign, ob_req_poffset, ob_req_ppaddr}),
    .out_valid(l1tol2_req_valid), .out_retry(l1tol2_req_retry),
    .out_data({req_cmd_bits, req_pcsign, req_poffset, req_ppaddr})
  );

  dc_fflop #(.WIDTH($bits(hpaddr_t))) u_ff_tlb (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ob_tlb_valid), .in_retry(ob_tlb_retry), .in_data(ob_tlb_hpaddr),
    .out_valid(l1tol2tlb_req_valid), .out_retry(l1tol2tlb_req_retry),
    .out_data(tlb_hpaddr)
  );

  // ack has no payload, a constant bit rides along
  dc_fflop #(.WIDTH(1)) u_ff_ack (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ob_ack_valid), .in_retry(ob_ack_retry), .in_data(1'b1),
    .out_valid(dctocore_std_ack_valid), .out_retry(dctocore_std_ack_retry),
    .out_data()
  );

  dc_fflop #(.WIDTH($bits(line_t))) u_ff_ldo (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ob_ld_valid), .in_retry(ob_ld_retry), .in_data(ob_ld_data),
    .out_valid(dctocore_ld_valid), .out_retry(dctocore_ld_retry),
    .out_data(ld_data)
  );

  dc_fflop #(.WIDTH($bits(l2id_t))) u_ff_sack (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ob_sack_valid), .in_retry(ob_sack_retry), .in_data(ob_sack_l2id),
    .out_valid(l1tol2_snoop_ack_valid), .out_retry(l1tol2_snoop_ack_retry),
    .out_data(ack_l2id)
  );

endmodule

// ==== test/dcache_pipe_props.sv ====
`timescale 1ns/1ps

module dcache_pipe_props
  import dc_core_pkg::*, dc_l2_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     l1tol2_req_valid,
  input logic     l1tol2_req_retry,
  input l2_cmd_e  req_cmd,
  input pcsign_t  req_pcsign,
  input poffset_t req_poffset,
  input ppaddr_t  req_ppaddr,
  input logic     l1tol2tlb_req_valid,
  input logic     l1tol2tlb_req_retry,
  input hpaddr_t  tlb_hpaddr,
  input logic     dctocore_std_ack_valid,
  input logic     dctocore_std_ack_retry,
  input logic     dctocore_ld_valid,
  input logic     dctocore_ld_retry,
  input line_t    ld_data,
  input logic     l1tol2_snoop_ack_valid,
  input logic     l1tol2_snoop_ack_retry,
  input l2id_t    ack_l2id
);

  // --------------------------------------------------
  // a retried output keeps valid and payload
  // --------------------------------------------------
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    l1tol2_req_valid && l1tol2_req_retry |=>
      l1tol2_req_valid && $stable({req_cmd, req_pcsign, req_poffset, req_ppaddr}))
    else $error("l2 request changed while retried");

  tlb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    l1tol2tlb_req_valid && l1tol2tlb_req_retry |=>
      l1tol2tlb_req_valid && $stable(tlb_hpaddr))
    else $error("l2 tlb request changed while retried");

  // no payload on the store ack
  ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dctocore_std_ack_valid && dctocore_std_ack_retry |=> dctocore_std_ack_valid)
    else $error("store ack dropped while retried");

  ld_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dctocore_ld_valid && dctocore_ld_retry |=> dctocore_ld_valid && $stable(ld_data))
    else $error("load data changed while retried");

  sack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    l1tol2_snoop_ack_valid && l1tol2_snoop_ack_retry |=>
      l1tol2_snoop_ack_valid && $stable(ack_l2id))
    else $error("snoop ack changed while retried");

  // all buffers are empty while reset is held
  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !(l1tol2_req_valid || l1tol2tlb_req_valid || dctocore_std_ack_valid ||
                 dctocore_ld_valid || l1tol2_snoop_ack_valid))
    else $error("output valid high during reset");

endmodule

bind dcache_pipe dcache_pipe_props u_props (
  .clk(clk), .rst_n(rst_n),
  .l1tol2_req_valid(l1tol2_req_valid), .l1tol2_req_retry(l1tol2_req_retry),
  .req_cmd(req_cmd), .req_pcsign(req_pcsign), .req_poffset(req_poffset),
  .req_ppaddr(req_ppaddr),
  .l1tol2tlb_req_valid(l1tol2tlb_req_valid), .l1tol2tlb_req_retry(l1tol2tlb_req_retry),
  .tlb_hpaddr(tlb_hpaddr),
  .dctocore_std_ack_valid(dctocore_std_ack_valid),
  .dctocore_std_ack_retry(dctocore_std_ack_retry),
  .dctocore_ld_valid(dctocore_ld_valid), .dctocore_ld_retry(dctocore_ld_retry),
  .ld_data(ld_data),
  .l1tol2_snoop_ack_valid(l1tol2_snoop_ack_valid),
  .l1tol2_snoop_ack_retry(l1tol2_snoop_ack_retry), .ack_l2id(ack_l2id)
);

// ==== test/dcache_pipe_tb.sv ====
`timescale 1ns/1ps

module dcache_pipe_tb
  import dc_core_pkg::*, dc_l2_pkg::*;
();

  localparam int N_LD  = 16;
  localparam int N_ST  = 16;
  localparam int N_PRI = 4;
  localparam int N_SN  = 16;
  localparam int N_BP  = 24;
  // a priority round is two pairs, a back-pressure round is load, store and snack
  localparam int N_TXN = N_LD + N_ST + 2 * N_PRI + N_SN + 3 * N_BP;
  localparam int CYCLE_LIMIT = 40 * N_TXN + 16;

  typedef logic [$bits(pcsign_t)+$bits(poffset_t)-1:0] op_w_t;
  typedef logic [$bits(ppaddr_t)+$bits(hpaddr_t)-1:0] fwd_w_t;
  typedef logic [$bits(l2id_t)+$bits(line_t)-1:0] snack_w_t;
  typedef logic [$bits(l2_cmd_e)+$bits(op_w_t)+$bits(ppaddr_t)-1:0] req_w_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     coretodc_ld_valid = 1'b0;
  logic     coretodc_ld_retry;
  pcsign_t  ld_pcsign = '0;
  poffset_t ld_poffset = '0;
  logic     coretodc_std_valid = 1'b0;
  logic     coretodc_std_retry;
  pcsign_t  std_pcsign = '0;
  poffset_t std_poffset = '0;
  logic     l1tlbtol1_fwd0_valid = 1'b0;
  logic     l1tlbtol1_fwd0_retry;
  ppaddr_t  fwd0_ppaddr = '0;
  hpaddr_t  fwd0_hpaddr = '0;
  logic     l1tlbtol1_fwd1_valid = 1'b0;
  logic     l1tlbtol1_fwd1_retry;
  ppaddr_t  fwd1_ppaddr = '0;
  hpaddr_t  fwd1_hpaddr = '0;
  logic     l2tol1_snack_valid = 1'b0;
  logic     l2tol1_snack_retry;
  l2id_t    snack_l2id = '0;
  line_t    snack_line = '0;
  logic     l1tol2_req_valid;
  logic     l1tol2_req_retry = 1'b0;
  l2_cmd_e  req_cmd;
  pcsign_t  req_pcsign;
  poffset_t req_poffset;
  ppaddr_t  req_ppaddr;
  logic     l1tol2tlb_req_valid;
  logic     l1tol2tlb_req_retry = 1'b0;
  hpaddr_t  tlb_hpaddr;
  logic     dctocore_std_ack_valid;
  logic     dctocore_std_ack_retry = 1'b0;
  logic     dctocore_ld_valid;
  logic     dctocore_ld_retry = 1'b0;
  line_t    ld_data;
  logic     l1tol2_snoop_ack_valid;
  logic     l1tol2_snoop_ack_retry = 1'b0;
  l2id_t    ack_l2id;

  // words waiting to be offered on each input channel, head is on the pins
  op_w_t    ld_q[$];
  op_w_t    st_q[$];
  fwd_w_t   fwd0_q[$];
  fwd_w_t   fwd1_q[$];
  snack_w_t snack_q[$];
  // expected responses, one queue per kind so that order is kept per kind
  req_w_t   exp_ld_req[$];
  req_w_t   exp_st_req[$];
  hpaddr_t  exp_ld_hp[$];
  hpaddr_t  exp_st_hp[$];
  // tlb order follows the request order seen at the l2 port
  hpaddr_t  want_tlb[$];
  hpaddr_t  got_tlb[$];
  line_t    exp_line[$];
  l2id_t    exp_l2id[$];
  l2_cmd_e  cmd_log[$];

  integer seed = 32'h53632176;
  // 0 no retry, 1 random retry, 2 all outputs held
  int retry_mode = 0;
  int errors = 0;
  int checks = 0;
  int mon_errors = 0;
  int mon_checks = 0;
  int tests = 0;
  int cycles = 0;
  int st_sent = 0;
  int ack_cnt = 0;
  int in_retry_seen = 0;

  always #20 clk = ~clk;

  dcache_pipe u_dut (.*);

  // expected l2 request: command by kind, op fields from the core, page from the tlb
  function automatic req_w_t exp_req(input bit is_store, input pcsign_t pc,
                                     input poffset_t po, input ppaddr_t pp);
    l2_cmd_e cmd;
    cmd = is_store ? cmd_req_m : cmd_req_s;
    return {cmd, pc, po, pp};
  endfunction

  function automatic bit pick_retry(input bit coin);
    return (retry_mode == 2) ? 1'b1 : ((retry_mode == 1) ? coin : 1'b0);
  endfunction

  function automatic bit idle();
    return ld_q.size() == 0 && st_q.size() == 0 && fwd0_q.size() == 0 &&
           fwd1_q.size() == 0 && snack_q.size() == 0 && exp_ld_req.size() == 0 &&
           exp_st_req.size() == 0 && want_tlb.size() == 0 && got_tlb.size() == 0 &&
           exp_line.size() == 0 && exp_l2id.size() == 0 && !l1tol2_req_valid &&
           !l1tol2tlb_req_valid && !dctocore_std_ack_valid && !dctocore_ld_valid &&
           !l1tol2_snoop_ack_valid;
  endfunction

  // queue one core op with its tlb forward, plus what should come out
  task automatic send_pair(input bit is_store);
    pcsign_t  pc;
    poffset_t po;
    ppaddr_t  pp;
    hpaddr_t  hp;
    pc = pcsign_t'($random(seed));
    po = poffset_t'($random(seed));
    pp = ppaddr_t'($random(seed));
    hp = hpaddr_t'($random(seed));
    if (is_store) begin
      st_q.push_back({pc, po});
      fwd1_q.push_back({pp, hp});
      exp_st_req.push_back(exp_req(1'b1, pc, po, pp));
      exp_st_hp.push_back(hp);
      st_sent++;
    end else begin
      ld_q.push_back({pc, po});
      fwd0_q.push_back({pp, hp});
      exp_ld_req.push_back(exp_req(1'b0, pc, po, pp));
      exp_ld_hp.push_back(hp);
    end
  endtask

  task automatic send_snack();
    l2id_t id;
    line_t ln;
    id = l2id_t'($random(seed));
    ln = {$random(seed), $random(seed)};
    snack_q.push_back({id, ln});
    exp_line.push_back(ln);
    exp_l2id.push_back(id);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!idle())
      @(negedge clk);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %-12s done, %0d errors", name, errors + mon_errors - err_before);
  endtask

  // --------------------------------------------------
  // drivers, inputs change 1 ns after the edge
  // --------------------------------------------------
  always @(posedge clk) begin
    integer rnd;
    // a word leaves its queue once the dut took it
    if (rst_n) begin
      if (coretodc_ld_valid && !coretodc_ld_retry)
        void'(ld_q.pop_front());
      if (coretodc_std_valid && !coretodc_std_retry)
        void'(st_q.pop_front());
      if (l1tlbtol1_fwd0_valid && !l1tlbtol1_fwd0_retry)
        void'(fwd0_q.pop_front());
      if (l1tlbtol1_fwd1_valid && !l1tlbtol1_fwd1_retry)
        void'(fwd1_q.pop_front());
      if (l2tol1_snack_valid && !l2tol1_snack_retry)
        void'(snack_q.pop_front());
    end
    #1;
    coretodc_ld_valid = (ld_q.size() != 0);
    if (ld_q.size() != 0)
      {ld_pcsign, ld_poffset} = ld_q[0];
    coretodc_std_valid = (st_q.size() != 0);
    if (st_q.size() != 0)
      {std_pcsign, std_poffset} = st_q[0];
    l1tlbtol1_fwd0_valid = (fwd0_q.size() != 0);
    if (fwd0_q.size() != 0)
      {fwd0_ppaddr, fwd0_hpaddr} = fwd0_q[0];
    l1tlbtol1_fwd1_valid = (fwd1_q.size() != 0);
    if (fwd1_q.size() != 0)
      {fwd1_ppaddr, fwd1_hpaddr} = fwd1_q[0];
    l2tol1_snack_valid = (snack_q.size() != 0);
    if (snack_q.size() != 0)
      {snack_l2id, snack_line} = snack_q[0];
    rnd = $random(seed);
    l1tol2_req_retry       = pick_retry(rnd[0]);
    l1tol2tlb_req_retry    = pick_retry(rnd[1]);
    dctocore_std_ack_retry = pick_retry(rnd[2]);
    dctocore_ld_retry      = pick_retry(rnd[3]);
    l1tol2_snoop_ack_retry = pick_retry(rnd[4]);
  end

  // --------------------------------------------------
  // compare on every output transfer
  // --------------------------------------------------
  always @(posedge clk) begin
    req_w_t  got;
    req_w_t  want;
    bit      have;
    hpaddr_t th;
    if (rst_n) begin
      if (l1tol2_req_valid && !l1tol2_req_retry) begin
        got = {req_cmd, req_pcsign, req_poffset, req_ppaddr};
        cmd_log.push_back(req_cmd);
        have = (req_cmd == cmd_req_s) ? (exp_ld_req.size() != 0) : (exp_st_req.size() != 0);
        mon_checks++;
        assert (have) else begin
          $display("l2 request of kind %h arrived with none of that kind pending", req_cmd);
          mon_errors++;
        end
        if (have && req_cmd == cmd_req_s) begin
          want = exp_ld_req.pop_front();
          want_tlb.push_back(exp_ld_hp.pop_front());
        end else if (have) begin
          want = exp_st_req.pop_front();
          want_tlb.push_back(exp_st_hp.pop_front());
        end
        if (have) begin
          mon_checks++;
          assert (got == want) else begin
            $display("Mismatch l1tol2_req: got %h expected %h", got, want);
            mon_errors++;
          end
        end
      end
      if (l1tol2tlb_req_valid && !l1tol2tlb_req_retry)
        got_tlb.push_back(tlb_hpaddr);
      while (got_tlb.size() != 0 && want_tlb.size() != 0) begin
        th = want_tlb.pop_front();
        mon_checks++;
        assert (got_tlb[0] == th) else begin
          $display("Mismatch tlb_hpaddr: got %h expected %h", got_tlb[0], th);
          mon_errors++;
        end
        void'(got_tlb.pop_front());
      end
      if (dctocore_std_ack_valid && !dctocore_std_ack_retry)
        ack_cnt++;
      if (dctocore_ld_valid && !dctocore_ld_retry) begin
        mon_checks++;
        assert (exp_line.size() != 0) else begin
          $display("load data returned to the core with no snack pending");
          mon_errors++;
        end
        if (exp_line.size() != 0) begin
          mon_checks++;
          assert (ld_data == exp_line[0]) else begin
            $display("Mismatch ld_data: got %h expected %h", ld_data, exp_line[0]);
            mon_errors++;
          end
          void'(exp_line.pop_front());
        end
      end
      if (l1tol2_snoop_ack_valid && !l1tol2_snoop_ack_retry) begin
        mon_checks++;
        assert (exp_l2id.size() != 0) else begin
          $display("snoop ack sent to l2 with no snack pending");
          mon_errors++;
        end
        if (exp_l2id.size() != 0) begin
          mon_checks++;
          assert (ack_l2id == exp_l2id[0]) else begin
            $display("Mismatch ack_l2id: got %h expected %h", ack_l2id, exp_l2id[0]);
            mon_errors++;
          end
          void'(exp_l2id.pop_front());
        end
      end
      // input side back-pressure while every output is held
      if (retry_mode == 2 && (coretodc_ld_retry || coretodc_std_retry ||
          l1tlbtol1_fwd0_retry || l1tlbtol1_fwd1_retry || l2tol1_snack_retry))
        in_retry_seen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int e0;
    int base;
    int seen0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    e0 = 0;
    @(negedge clk);
    checks++;
    assert (!l1tol2_req_valid && !l1tol2tlb_req_valid && !dctocore_std_ack_valid &&
            !dctocore_ld_valid && !l1tol2_snoop_ack_valid && !coretodc_ld_retry &&
            !coretodc_std_retry && !l1tlbtol1_fwd0_retry && !l1tlbtol1_fwd1_retry &&
            !l2tol1_snack_retry) else begin
      $display("an output valid or retry is high after reset");
      errors++;
    end
    end_test("reset", e0);

    e0 = errors + mon_errors;
    @(posedge clk);
    for (int i = 0; i < N_LD; i++)
      send_pair(1'b0);
    wait_idle();
    end_test("loads", e0);

    e0 = errors + mon_errors;
    @(posedge clk);
    for (int i = 0; i < N_ST; i++)
      send_pair(1'b1);
    wait_idle();
    checks++;
    assert (ack_cnt == st_sent) else begin
      $display("Mismatch dctocore_std_ack count: got %h expected %h", ack_cnt, st_sent);
      errors++;
    end
    end_test("stores", e0);

    // both pairs land in the arbiter in the same cycle
    e0 = errors + mon_errors;
    for (int r = 0; r < N_PRI; r++) begin
      base = cmd_log.size();
      @(posedge clk);
      send_pair(1'b0);
      send_pair(1'b1);
      wait_idle();
      checks++;
      assert (cmd_log.size() == base + 2 && cmd_log[base] == cmd_req_s &&
              cmd_log[base+1] == cmd_req_m) else begin
        $display("store request was not ordered after the load in round %0d", r);
        errors++;
      end
    end
    end_test("priority", e0);

    e0 = errors + mon_errors;
    @(posedge clk);
    for (int i = 0; i < N_SN; i++)
      send_snack();
    wait_idle();
    end_test("snack", e0);

    // hold every output first so the buffers fill, then random retry
    e0 = errors + mon_errors;
    seen0 = in_retry_seen;
    retry_mode = 2;
    @(posedge clk);
    for (int i = 0; i < N_BP; i++) begin
      send_pair(1'b0);
      send_pair(1'b1);
      send_snack();
    end
    repeat (12) @(posedge clk);
    retry_mode = 1;
    wait_idle();
    retry_mode = 0;
    checks++;
    assert (in_retry_seen > seen0) else begin
      $display("no input retry was seen while all outputs were held");
      errors++;
    end
    checks++;
    assert (ack_cnt == st_sent) else begin
      $display("Mismatch dctocore_std_ack count: got %h expected %h", ack_cnt, st_sent);
      errors++;
    end
    end_test("backpressure", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks + mon_checks,
             errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/dc_core_pkg.sv
rtl/dc_l2_pkg.sv
rtl/dc_fflop.sv
rtl/dc_miss_arb.sv
rtl/dc_snack_fork.sv
rtl/dcache_pipe.sv
test/dcache_pipe_props.sv
test/dcache_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module dcache_pipe_tb -o sim

./obj_dir/sim 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: pass"
else
  echo "run.sh: fail"
  exit 1
fi
